//--- common/rp_pkg.sv
// shared definitions for the converter-side design
// sample and bus widths, register bus region map, register offsets
// and constants of the proportional controllers
package rp_pkg;

  // ----------------------------------------------------------
  // widths
  localparam int adc_w  = 14;            // converter sample width
  localparam int sum_w  = 15;            // sum before saturation
  localparam int prod_w = adc_w + sum_w; // gain x error product
  localparam int bus_w  = 32;            // bus address and data

  // ----------------------------------------------------------
  // region map, region field sits at addr[22:20]
  localparam int region_lsb = 20;
  localparam int region_n   = 8;
  localparam int region_w   = $clog2(region_n);
  localparam int region_asg = 2; // DC generator
  localparam int region_pid = 3; // controller registers

  typedef logic signed [adc_w-1:0] sample_t;

  localparam sample_t sample_max = sample_t'(8191);
  localparam sample_t sample_min = sample_t'(-8192);
  localparam logic [adc_w-1:0] dac_mid = 14'h2000; // offset-binary zero

  // ----------------------------------------------------------
  // register offsets inside a region
  localparam logic [region_lsb-1:0] asg_level_a_off = 'h00;
  localparam logic [region_lsb-1:0] asg_level_b_off = 'h04;
  localparam logic [region_lsb-1:0] pid_sp_a_off    = 'h00;
  localparam logic [region_lsb-1:0] pid_kp_a_off    = 'h04;
  localparam logic [region_lsb-1:0] pid_sp_b_off    = 'h08;
  localparam logic [region_lsb-1:0] pid_kp_b_off    = 'h0C;
  localparam logic [region_lsb-1:0] pid_en_off      = 'h10; // bit0 ch a, bit1 ch b

  localparam int kp_shift = 12; // gain scaling, kp of 4096 is unity

  // sample to bus word, sign extended
  function automatic logic [bus_w-1:0] sext(sample_t v);
    return {{(bus_w-adc_w){v[adc_w-1]}}, v};
  endfunction

endpackage

//--- hdl/rp_sys_decoder.sv
// system bus decoder
// splits the address space into eight regions on addr[22:20], routes the
// strobes and muxes the response of the addressed region back to the master
// empty regions get a zero-data acknowledge from here
`timescale 1ns/1ns

module rp_sys_decoder (
  input  logic                     adc_clk,
  input  logic                     rst_n_i,
  input  logic [rp_pkg::bus_w-1:0] sys_addr_i,
  input  logic                     sys_wen_i,
  input  logic                     sys_ren_i,
  output logic [rp_pkg::bus_w-1:0] sys_rdata_o,
  output logic                     sys_ack_o,
  output logic                     sys_err_o,
  output logic                     asg_wen_o,
  output logic                     asg_ren_o,
  output logic                     pid_wen_o,
  output logic                     pid_ren_o,
  input  logic [rp_pkg::bus_w-1:0] asg_rdata_i,
  input  logic                     asg_ack_i,
  input  logic                     asg_err_i,
  input  logic [rp_pkg::bus_w-1:0] pid_rdata_i,
  input  logic                     pid_ack_i,
  input  logic                     pid_err_i
);

  logic [rp_pkg::region_w-1:0] region;   // live region field
  logic [rp_pkg::region_w-1:0] region_q; // region of the pending access
  logic                        strobe_q; // strobe seen last cycle
  logic                        asg_sel;
  logic                        pid_sel;

  assign region  = sys_addr_i[rp_pkg::region_lsb +: rp_pkg::region_w];
  assign asg_sel = (region == rp_pkg::region_w'(rp_pkg::region_asg));
  assign pid_sel = (region == rp_pkg::region_w'(rp_pkg::region_pid));

  assign asg_wen_o = sys_wen_i & asg_sel; // strobe fan-out
  assign asg_ren_o = sys_ren_i & asg_sel;
  assign pid_wen_o = sys_wen_i & pid_sel;
  assign pid_ren_o = sys_ren_i & pid_sel;

  // ----------------------------------------------------------
  // hold region so the response follows the strobe, not addr
  always_ff @(posedge adc_clk) begin
    if (!rst_n_i) begin
      region_q <= '0;
      strobe_q <= 1'b0;
    end else begin
      strobe_q <= sys_wen_i | sys_ren_i;
      if (sys_wen_i || sys_ren_i) begin
        region_q <= region; // latch on strobe only
      end
    end
  end

  // ----------------------------------------------------------
  // response mux
  always_comb begin
    case (region_q)
      rp_pkg::region_w'(rp_pkg::region_asg): begin
        sys_rdata_o = asg_rdata_i;
        sys_ack_o   = asg_ack_i;
        sys_err_o   = asg_err_i;
      end
      rp_pkg::region_w'(rp_pkg::region_pid): begin
        sys_rdata_o = pid_rdata_i;
        sys_ack_o   = pid_ack_i;
        sys_err_o   = pid_err_i;
      end
      default: begin
        sys_rdata_o = '0;       // empty region reads zero
        sys_ack_o   = strobe_q; // one cycle after strobe
        sys_err_o   = 1'b0;
      end
    endcase
  end

endmodule

//--- analog/rp_adc_frontend.sv
// ADC front end
// turns the negative-slope unsigned converter codes of both channels
// into two's complement samples, one register stage
`timescale 1ns/1ns

module rp_adc_frontend (
  input  logic                     adc_clk,
  input  logic                     rst_n_i,
  input  logic [rp_pkg::adc_w-1:0] adc_dat_a_i, // raw ch a
  input  logic [rp_pkg::adc_w-1:0] adc_dat_b_i, // raw ch b
  output rp_pkg::sample_t          adc_a_o,
  output rp_pkg::sample_t          adc_b_o
);

  localparam int msb = rp_pkg::adc_w - 1;

  // 8191 - raw is just the low bits inverted, msb kept
  // raw 0 -> +8191, raw 16383 -> -8192
  always_ff @(posedge adc_clk) begin
    if (!rst_n_i) begin
      adc_a_o <= '0;
      adc_b_o <= '0;
    end else begin
      adc_a_o <= {adc_dat_a_i[msb], ~adc_dat_a_i[msb-1:0]}; // ch a
      adc_b_o <= {adc_dat_b_i[msb], ~adc_dat_b_i[msb-1:0]}; // ch b
    end
  end

endmodule

//--- asg/rp_asg_dc.sv
// DC generator
// one bus-writable signed level per channel, read back sign extended
// unmapped offsets answer with err
`timescale 1ns/1ns

module rp_asg_dc (
  input  logic                     adc_clk,
  input  logic                     rst_n_i,
  input  logic [rp_pkg::bus_w-1:0] sys_addr_i,
  input  logic [rp_pkg::bus_w-1:0] sys_wdata_i,
  input  logic                     sys_wen_i,
  input  logic                     sys_ren_i,
  output logic [rp_pkg::bus_w-1:0] sys_rdata_o,
  output logic                     sys_ack_o,
  output logic                     sys_err_o,
  output rp_pkg::sample_t          level_a_o,
  output rp_pkg::sample_t          level_b_o
);

  logic [rp_pkg::region_lsb-1:0] off;    // offset inside region
  logic                          hit;    // offset is mapped
  logic [rp_pkg::bus_w-1:0]      rd_val; // readback word

  assign off = sys_addr_i[rp_pkg::region_lsb-1:0];

  always_comb begin
    hit    = 1'b1;
    rd_val = '0;
    case (off)
      rp_pkg::asg_level_a_off: rd_val = rp_pkg::sext(level_a_o);
      rp_pkg::asg_level_b_off: rd_val = rp_pkg::sext(level_b_o);
      default:                 hit    = 1'b0;
    endcase
  end

  always_ff @(posedge adc_clk) begin
    if (!rst_n_i) begin
      level_a_o   <= '0;
      level_b_o   <= '0;
      sys_ack_o   <= 1'b0;
      sys_err_o   <= 1'b0;
      sys_rdata_o <= '0;
    end else begin
      sys_ack_o   <= sys_wen_i | sys_ren_i;          // ack next cycle
      sys_err_o   <= (sys_wen_i | sys_ren_i) & ~hit; // unmapped
      sys_rdata_o <= (sys_ren_i & hit) ? rd_val : '0;
      if (sys_wen_i && off == rp_pkg::asg_level_a_off) begin
        level_a_o <= sys_wdata_i[rp_pkg::adc_w-1:0]; // low 14 bits
      end
      if (sys_wen_i && off == rp_pkg::asg_level_b_off) begin
        level_b_o <= sys_wdata_i[rp_pkg::adc_w-1:0];
      end
    end
  end

endmodule

//--- pid/rp_pid_regs.sv
// controller register block
// setpoints, gains and enables of both proportional channels
// signed values read back sign extended, enables as two bits
`timescale 1ns/1ns

module rp_pid_regs (
  input  logic                     adc_clk,
  input  logic                     rst_n_i,
  input  logic [rp_pkg::bus_w-1:0] sys_addr_i,
  input  logic [rp_pkg::bus_w-1:0] sys_wdata_i,
  input  logic                     sys_wen_i,
  input  logic                     sys_ren_i,
  output logic [rp_pkg::bus_w-1:0] sys_rdata_o,
  output logic                     sys_ack_o,
  output logic                     sys_err_o,
  output rp_pkg::sample_t          sp_a_o,
  output rp_pkg::sample_t          kp_a_o,
  output rp_pkg::sample_t          sp_b_o,
  output rp_pkg::sample_t          kp_b_o,
  output logic                     en_a_o,
  output logic                     en_b_o
);

  logic [rp_pkg::region_lsb-1:0] off;
  logic                          hit;
  logic [rp_pkg::bus_w-1:0]      rd_val;
  rp_pkg::sample_t               wval;   // write data, low 14 bits

  assign off  = sys_addr_i[rp_pkg::region_lsb-1:0];
  assign wval = sys_wdata_i[rp_pkg::adc_w-1:0];

  // ----------------------------------------------------------
  // readback decode
  always_comb begin
    hit    = 1'b1;
    rd_val = '0;
    case (off)
      rp_pkg::pid_sp_a_off: rd_val = rp_pkg::sext(sp_a_o);
      rp_pkg::pid_kp_a_off: rd_val = rp_pkg::sext(kp_a_o);
      rp_pkg::pid_sp_b_off: rd_val = rp_pkg::sext(sp_b_o);
      rp_pkg::pid_kp_b_off: rd_val = rp_pkg::sext(kp_b_o);
      rp_pkg::pid_en_off:   rd_val = {{(rp_pkg::bus_w-2){1'b0}}, en_b_o, en_a_o};
      default:              hit    = 1'b0; // err, read zero
    endcase
  end

  always_ff @(posedge adc_clk) begin
    if (!rst_n_i) begin
      sp_a_o      <= '0;
      kp_a_o      <= '0;
      sp_b_o      <= '0;
      kp_b_o      <= '0;
      en_a_o      <= 1'b0; // controllers off
      en_b_o      <= 1'b0;
      sys_ack_o   <= 1'b0;
      sys_err_o   <= 1'b0;
      sys_rdata_o <= '0;
    end else begin
      sys_ack_o   <= sys_wen_i | sys_ren_i;
      sys_err_o   <= (sys_wen_i | sys_ren_i) & ~hit;
      sys_rdata_o <= (sys_ren_i & hit) ? rd_val : '0;
      if (sys_wen_i) begin
        case (off)
          rp_pkg::pid_sp_a_off: sp_a_o <= wval;
          rp_pkg::pid_kp_a_off: kp_a_o <= wval;
          rp_pkg::pid_sp_b_off: sp_b_o <= wval;
          rp_pkg::pid_kp_b_off: kp_b_o <= wval;
          rp_pkg::pid_en_off: begin
            en_a_o <= sys_wdata_i[0];
            en_b_o <= sys_wdata_i[1];
          end
          default: ; // erroring write changes nothing
        endcase
      end
    end
  end

endmodule

//--- pid/rp_pid_core.sv
// proportional controller, one channel
// stage 1 registers the error, stage 2 the scaled and clamped
// product of gain and error; output held at zero while disabled
`timescale 1ns/1ns

module rp_pid_core (
  input  logic            adc_clk,
  input  logic            rst_n_i,
  input  rp_pkg::sample_t sample_i,
  input  rp_pkg::sample_t setpoint_i,
  input  rp_pkg::sample_t kp_i,
  input  logic            en_i,
  output rp_pkg::sample_t ctrl_o
);

  logic signed [rp_pkg::sum_w-1:0]  err_q;    // setpoint - sample, no wrap
  logic signed [rp_pkg::prod_w-1:0] prod;     // full product
  logic signed [rp_pkg::prod_w-1:0] prod_sh;  // scaled by kp_shift
  rp_pkg::sample_t                  ctrl_sat; // clamped to sample range

  // ----------------------------------------------------------
  // stage 1, error
  always_ff @(posedge adc_clk) begin
    if (!rst_n_i) begin
      err_q <= '0;
    end else begin
      err_q <= setpoint_i - sample_i; // 15 bit, both sign extended
    end
  end

  assign prod    = kp_i * err_q;                // signed multiply
  assign prod_sh = prod >>> rp_pkg::kp_shift;   // arithmetic shift

  always_comb begin
    if (prod_sh > rp_pkg::sample_max) begin
      ctrl_sat = rp_pkg::sample_max;            // clip high
    end else if (prod_sh < rp_pkg::sample_min) begin
      ctrl_sat = rp_pkg::sample_min;            // clip low
    end else begin
      ctrl_sat = prod_sh[rp_pkg::adc_w-1:0];
    end
  end

  // ----------------------------------------------------------
  // stage 2, output
  always_ff @(posedge adc_clk) begin
    if (!rst_n_i) begin
      ctrl_o <= '0;
    end else begin
      ctrl_o <= en_i ? ctrl_sat : '0; // disabled channel outputs zero
    end
  end

endmodule

//--- hdl/rp_dac_mixer.sv
// DAC mixer
// adds generator and controller outputs per channel with saturation
// and registers the offset-binary DAC code
`timescale 1ns/1ns

module rp_dac_mixer (
  input  logic                     adc_clk,
  input  logic                     rst_n_i,
  input  rp_pkg::sample_t          asg_a_i,
  input  rp_pkg::sample_t          asg_b_i,
  input  rp_pkg::sample_t          pid_a_i,
  input  rp_pkg::sample_t          pid_b_i,
  output logic [rp_pkg::adc_w-1:0] dac_a_o,
  output logic [rp_pkg::adc_w-1:0] dac_b_o
);

  // saturating add, then msb flip to offset binary
  function automatic logic [rp_pkg::adc_w-1:0] to_dac(rp_pkg::sample_t a,
                                                      rp_pkg::sample_t b);
    logic signed [rp_pkg::sum_w-1:0] sum;
    rp_pkg::sample_t                 sat;
    sum = a + b; // one guard bit
    if (sum[rp_pkg::sum_w-1 -: 2] == 2'b01) begin
      sat = rp_pkg::sample_max; // pos. overflow
    end else if (sum[rp_pkg::sum_w-1 -: 2] == 2'b10) begin
      sat = rp_pkg::sample_min; // neg. overflow
    end else begin
      sat = sum[rp_pkg::adc_w-1:0];
    end
    return {~sat[rp_pkg::adc_w-1], sat[rp_pkg::adc_w-2:0]};
  endfunction

  always_ff @(posedge adc_clk) begin
    if (!rst_n_i) begin
      dac_a_o <= rp_pkg::dac_mid; // code for zero
      dac_b_o <= rp_pkg::dac_mid;
    end else begin
      dac_a_o <= to_dac(asg_a_i, pid_a_i);
      dac_b_o <= to_dac(asg_b_i, pid_b_i);
    end
  end

endmodule

//--- hdl/rp_top.sv
// top level of the converter-side design
// bus decoder, ADC front end, DC generator, two proportional
// controllers with their register block, and the DAC mixer
`timescale 1ns/1ns

module rp_top (
  input  logic                     adc_clk,
  input  logic                     rst_n_i,
  input  logic [rp_pkg::adc_w-1:0] adc_dat_a_i,
  input  logic [rp_pkg::adc_w-1:0] adc_dat_b_i,
  input  logic [rp_pkg::bus_w-1:0] sys_addr_i,
  input  logic [rp_pkg::bus_w-1:0] sys_wdata_i,
  input  logic                     sys_wen_i,
  input  logic                     sys_ren_i,
  output logic [rp_pkg::bus_w-1:0] sys_rdata_o,
  output logic                     sys_ack_o,
  output logic                     sys_err_o,
  output logic [rp_pkg::adc_w-1:0] dac_a_o,
  output logic [rp_pkg::adc_w-1:0] dac_b_o
);

  logic                     asg_wen, asg_ren, asg_ack, asg_err;
  logic                     pid_wen, pid_ren, pid_ack, pid_err;
  logic [rp_pkg::bus_w-1:0] asg_rdata;
  logic [rp_pkg::bus_w-1:0] pid_rdata;
  rp_pkg::sample_t          adc_a, adc_b;     // two's complement samples
  rp_pkg::sample_t          level_a, level_b; // generator levels
  rp_pkg::sample_t          sp_a, kp_a, sp_b, kp_b;
  logic                     en_a, en_b;
  rp_pkg::sample_t          pid_a, pid_b;     // controller outputs

  // ----------------------------------------------------------
  // register bus
  rp_sys_decoder u_dec (
    .adc_clk     (adc_clk),
    .rst_n_i     (rst_n_i),
    .sys_addr_i  (sys_addr_i),
    .sys_wen_i   (sys_wen_i),
    .sys_ren_i   (sys_ren_i),
    .sys_rdata_o (sys_rdata_o),
    .sys_ack_o   (sys_ack_o),
    .sys_err_o   (sys_err_o),
    .asg_wen_o   (asg_wen),   // region 2
    .asg_ren_o   (asg_ren),
    .pid_wen_o   (pid_wen),   // region 3
    .pid_ren_o   (pid_ren),
    .asg_rdata_i (asg_rdata),
    .asg_ack_i   (asg_ack),
    .asg_err_i   (asg_err),
    .pid_rdata_i (pid_rdata),
    .pid_ack_i   (pid_ack),
    .pid_err_i   (pid_err)
  );

  // ----------------------------------------------------------
  // datapath
  rp_adc_frontend u_adc (
    .adc_clk     (adc_clk),
    .rst_n_i     (rst_n_i),
    .adc_dat_a_i (adc_dat_a_i),
    .adc_dat_b_i (adc_dat_b_i),
    .adc_a_o     (adc_a),
    .adc_b_o     (adc_b)
  );

  rp_asg_dc u_asg (
    .adc_clk     (adc_clk),
    .rst_n_i     (rst_n_i),
    .sys_addr_i  (sys_addr_i),
    .sys_wdata_i (sys_wdata_i),
    .sys_wen_i   (asg_wen),
    .sys_ren_i   (asg_ren),
    .sys_rdata_o (asg_rdata),
    .sys_ack_o   (asg_ack),
    .sys_err_o   (asg_err),
    .level_a_o   (level_a),
    .level_b_o   (level_b)
  );

  rp_pid_regs u_pid_regs (
    .adc_clk     (adc_clk),
    .rst_n_i     (rst_n_i),
    .sys_addr_i  (sys_addr_i),
    .sys_wdata_i (sys_wdata_i),
    .sys_wen_i   (pid_wen),
    .sys_ren_i   (pid_ren),
    .sys_rdata_o (pid_rdata),
    .sys_ack_o   (pid_ack),
    .sys_err_o   (pid_err),
    .sp_a_o      (sp_a),
    .kp_a_o      (kp_a),
    .sp_b_o      (sp_b),
    .kp_b_o      (kp_b),
    .en_a_o      (en_a),
    .en_b_o      (en_b)
  );

  rp_pid_core u_pid_a (
    .adc_clk    (adc_clk),
    .rst_n_i    (rst_n_i),
    .sample_i   (adc_a),   // ch a in
    .setpoint_i (sp_a),
    .kp_i       (kp_a),
    .en_i       (en_a),
    .ctrl_o     (pid_a)
  );

  rp_pid_core u_pid_b (
    .adc_clk    (adc_clk),
    .rst_n_i    (rst_n_i),
    .sample_i   (adc_b),   // ch b in
    .setpoint_i (sp_b),
    .kp_i       (kp_b),
    .en_i       (en_b),
    .ctrl_o     (pid_b)
  );

  rp_dac_mixer u_mix (
    .adc_clk (adc_clk),
    .rst_n_i (rst_n_i),
    .asg_a_i (level_a),
    .asg_b_i (level_b),
    .pid_a_i (pid_a),
    .pid_b_i (pid_b),
    .dac_a_o (dac_a_o),
    .dac_b_o (dac_b_o)
  );

endmodule

//--- verif/rp_top_asserts.sv
// bus handshake and reset-state checks for the top level
// bound into rp_top, watches the master side of the register bus
`timescale 1ns/1ns

module rp_top_asserts (
  input logic                     adc_clk,
  input logic                     rst_n_i,
  input logic                     wen_i,
  input logic                     ren_i,
  input logic [rp_pkg::bus_w-1:0] rdata_i,
  input logic                     ack_i,
  input logic                     err_i,
  input logic [rp_pkg::adc_w-1:0] dac_a_i,
  input logic [rp_pkg::adc_w-1:0] dac_b_i
);

  int unsigned fail_cnt = 0; // assertion failures so far

  // ----------------------------------------------------------
  // handshake
  ack_after_strobe: assert property (@(posedge adc_clk) disable iff (!rst_n_i)
    (wen_i || ren_i) |=> ack_i)
    else begin
      $error("bus strobe not acknowledged on the next cycle");
      fail_cnt++;
    end

  ack_needs_strobe: assert property (@(posedge adc_clk) disable iff (!rst_n_i)
    ack_i |-> $past(wen_i || ren_i))
    else begin
      $error("bus ack without a strobe one cycle before");
      fail_cnt++;
    end

  ack_single_cycle: assert property (@(posedge adc_clk) disable iff (!rst_n_i)
    ack_i |=> !ack_i)
    else begin
      $error("bus ack held longer than one cycle");
      fail_cnt++;
    end

  err_with_ack: assert property (@(posedge adc_clk) disable iff (!rst_n_i)
    err_i |-> ack_i)
    else begin
      $error("bus err raised without ack");
      fail_cnt++;
    end

  // ----------------------------------------------------------
  // first cycle out of reset
  reset_state: assert property (@(posedge adc_clk)
    $rose(rst_n_i) |-> (!ack_i && !err_i && rdata_i == '0 &&
                        dac_a_i == rp_pkg::dac_mid && dac_b_i == rp_pkg::dac_mid))
    else begin
      $error("outputs not at reset values after reset release");
      fail_cnt++;
    end

endmodule

bind rp_top rp_top_asserts u_asserts (
  .adc_clk (adc_clk),
  .rst_n_i (rst_n_i),
  .wen_i   (sys_wen_i),
  .ren_i   (sys_ren_i),
  .rdata_i (sys_rdata_o),
  .ack_i   (sys_ack_o),
  .err_i   (sys_err_o),
  .dac_a_i (dac_a_o),
  .dac_b_i (dac_b_o)
);

//--- verif/tb_rp_top.sv
// testbench for the converter-side top level
// register bus accesses, readback, generator and controller paths
// to the DAC outputs, saturation; values checked by immediate asserts
`timescale 1ns/1ns

module tb_rp_top;

  localparam int max_cycles = 3000; // tests need about 600
  localparam int ack_wait   = 8;    // cycles to wait for ack
  localparam int smax       = 8191;
  localparam int smin       = -8192;

  localparam logic [31:0] asg_base = 32'(rp_pkg::region_asg) << rp_pkg::region_lsb;
  localparam logic [31:0] pid_base = 32'(rp_pkg::region_pid) << rp_pkg::region_lsb;
  localparam logic [31:0] asg_lvl_a = asg_base + 32'(rp_pkg::asg_level_a_off);
  localparam logic [31:0] asg_lvl_b = asg_base + 32'(rp_pkg::asg_level_b_off);
  localparam logic [31:0] asg_bad   = asg_base + 32'h08; // unmapped
  localparam logic [31:0] pid_sp_a  = pid_base + 32'(rp_pkg::pid_sp_a_off);
  localparam logic [31:0] pid_kp_a  = pid_base + 32'(rp_pkg::pid_kp_a_off);
  localparam logic [31:0] pid_sp_b  = pid_base + 32'(rp_pkg::pid_sp_b_off);
  localparam logic [31:0] pid_kp_b  = pid_base + 32'(rp_pkg::pid_kp_b_off);
  localparam logic [31:0] pid_en    = pid_base + 32'(rp_pkg::pid_en_off);
  localparam logic [31:0] pid_bad   = pid_base + 32'h14; // unmapped

  logic        adc_clk = 1'b0;
  logic        rst_n_i;
  logic [13:0] adc_dat_a_i;
  logic [13:0] adc_dat_b_i;
  logic [31:0] sys_addr_i;
  logic [31:0] sys_wdata_i;
  logic        sys_wen_i;
  logic        sys_ren_i;
  logic [31:0] sys_rdata_o;
  logic        sys_ack_o;
  logic        sys_err_o;
  logic [13:0] dac_a_o;
  logic [13:0] dac_b_o;

  int    seed   = 99088;
  int    cycles = 0;
  int    n_pass = 0;
  int    n_fail = 0;
  int    mism   = 0;  // mismatches in running test
  string tname  = "";
  int    empty_regions[6] = '{0, 1, 4, 5, 6, 7};

  rp_top DUT (.*);

  always #5 adc_clk = ~adc_clk; // 10 ns period

  always @(posedge adc_clk) begin
    cycles <= cycles + 1;
    if (cycles >= max_cycles) begin
      $display("timeout: run stopped after %0d cycles", cycles);
      $display("Result: FAILED");
      $finish;
    end
  end

  // ----------------------------------------------------------
  // reference model, straight from the datapath rules
  function automatic int clamp_sample(int v);
    if (v > smax) return smax;
    if (v < smin) return smin;
    return v;
  endfunction

  function automatic int low14(logic [31:0] w); // signed low 14 bits
    return w[13] ? int'(w[13:0]) - 16384 : int'(w[13:0]);
  endfunction

  function automatic int ctrl_value(int sp, int kp, int raw);
    return clamp_sample((kp * (sp - (8191 - raw))) >>> 12);
  endfunction

  function automatic logic [31:0] offset_code(int v); // zero -> 0x2000
    return 32'((v + 8192) & 32'h3FFF);
  endfunction

  // ----------------------------------------------------------
  // bookkeeping
  task automatic begin_test(input string name);
    tname = name;
    mism  = 0;
  endtask

  task automatic end_test();
    if (mism == 0) begin
      $display("test %s: pass", tname);
      n_pass++;
    end else begin
      $display("test %s: %0d mismatches", tname, mism);
      n_fail++;
    end
  endtask

  task automatic check_val(input string what, input logic [31:0] exp, input logic [31:0] act);
    assert (act === exp) else begin
      $display("FAIL %s %s: expected 0x%08h, actual 0x%08h", tname, what, exp, act);
      mism++;
    end
  endtask

  task automatic wait_cycles(input int n);
    repeat (n) @(posedge adc_clk);
    @(negedge adc_clk); // outputs settled
  endtask

  // ----------------------------------------------------------
  // bus master
  task automatic wait_ack(input string what, input logic [31:0] addr);
    int n;
    n = 0;
    @(negedge adc_clk);
    while (!sys_ack_o && n < ack_wait) begin
      @(negedge adc_clk);
      n++;
    end
    if (!sys_ack_o) begin
      $display("%s: no acknowledge for %s at 0x%08h", tname, what, addr);
      mism++;
    end
  endtask

  task automatic bus_write(input logic [31:0] addr, input logic [31:0] data, output logic err);
    @(posedge adc_clk);
    sys_addr_i  <= addr;
    sys_wdata_i <= data;
    sys_wen_i   <= 1'b1; // single-cycle strobe
    @(posedge adc_clk);
    sys_wen_i   <= 1'b0;
    wait_ack("write", addr);
    err = sys_err_o;
  endtask

  task automatic bus_read(input logic [31:0] addr, output logic [31:0] data, output logic err);
    @(posedge adc_clk);
    sys_addr_i <= addr;
    sys_ren_i  <= 1'b1;
    @(posedge adc_clk);
    sys_ren_i  <= 1'b0;
    wait_ack("read", addr);
    data = sys_rdata_o; // valid in ack cycle
    err  = sys_err_o;
  endtask

  task automatic write_reg(input string what, input logic [31:0] addr,
                           input logic [31:0] data, input logic exp_err);
    logic err;
    bus_write(addr, data, err);
    check_val({what, " write err"}, 32'(exp_err), 32'(err));
  endtask

  task automatic read_reg(input string what, input logic [31:0] addr,
                          input logic [31:0] exp, input logic exp_err);
    logic [31:0] rd;
    logic        err;
    bus_read(addr, rd, err);
    check_val({what, " read data"}, exp, rd);
    check_val({what, " read err"}, 32'(exp_err), 32'(err));
  endtask

  task automatic set_levels(input int la, input int lb);
    write_reg("level a", asg_lvl_a, 32'(la), 1'b0);
    write_reg("level b", asg_lvl_b, 32'(lb), 1'b0);
  endtask

  task automatic set_pid(input int sp_a, input int kp_a, input int sp_b,
                         input int kp_b, input int en);
    write_reg("sp a", pid_sp_a, 32'(sp_a), 1'b0);
    write_reg("kp a", pid_kp_a, 32'(kp_a), 1'b0);
    write_reg("sp b", pid_sp_b, 32'(sp_b), 1'b0);
    write_reg("kp b", pid_kp_b, 32'(kp_b), 1'b0);
    write_reg("enable", pid_en, 32'(en), 1'b0);
  endtask

  task automatic drive_adc(input int raw_a, input int raw_b);
    @(posedge adc_clk);
    adc_dat_a_i <= 14'(raw_a);
    adc_dat_b_i <= 14'(raw_b);
  endtask

  task automatic run_ctrl_case(input int sp_a, input int kp_a, input int raw_a,
                               input int sp_b, input int kp_b, input int raw_b, input int en);
    int exp_a;
    int exp_b;
    drive_adc(raw_a, raw_b);
    set_pid(sp_a, kp_a, sp_b, kp_b, en);
    wait_cycles(6);
    exp_a = ((en & 1) != 0) ? ctrl_value(sp_a, kp_a, raw_a) : 0;
    exp_b = ((en & 2) != 0) ? ctrl_value(sp_b, kp_b, raw_b) : 0;
    check_val($sformatf("dac a en=%0d", en), offset_code(exp_a), 32'(dac_a_o));
    check_val($sformatf("dac b en=%0d", en), offset_code(exp_b), 32'(dac_b_o));
  endtask

  // ----------------------------------------------------------
  // stimulus
  initial begin
    logic [31:0] w;
    logic [31:0] addr;
    int          la;
    int          lb;
    rst_n_i     <= 1'b0;
    adc_dat_a_i <= '0;
    adc_dat_b_i <= '0;
    sys_addr_i  <= '0;
    sys_wdata_i <= '0;
    sys_wen_i   <= 1'b0;
    sys_ren_i   <= 1'b0;
    repeat (2) @(posedge adc_clk);
    rst_n_i <= 1'b1;

    begin_test("empty_regions"); // decoder answers itself
    foreach (empty_regions[i]) begin
      addr = (32'(empty_regions[i]) << rp_pkg::region_lsb) | 32'h10;
      read_reg($sformatf("region %0d", empty_regions[i]), addr, 32'h0, 1'b0);
      write_reg($sformatf("region %0d", empty_regions[i]), addr, $random(seed), 1'b0);
    end
    end_test();

    begin_test("readback");
    w = $random(seed);
    write_reg("level a", asg_lvl_a, w, 1'b0);
    read_reg("level a", asg_lvl_a, 32'(low14(w)), 1'b0);
    w = $random(seed);
    write_reg("level b", asg_lvl_b, w, 1'b0);
    read_reg("level b", asg_lvl_b, 32'(low14(w)), 1'b0);
    w = $random(seed);
    write_reg("sp a", pid_sp_a, w, 1'b0);
    read_reg("sp a", pid_sp_a, 32'(low14(w)), 1'b0);
    w = $random(seed);
    write_reg("kp a", pid_kp_a, w, 1'b0);
    read_reg("kp a", pid_kp_a, 32'(low14(w)), 1'b0);
    w = $random(seed);
    write_reg("sp b", pid_sp_b, w, 1'b0);
    read_reg("sp b", pid_sp_b, 32'(low14(w)), 1'b0);
    w = $random(seed);
    write_reg("kp b", pid_kp_b, w, 1'b0);
    read_reg("kp b", pid_kp_b, 32'(low14(w)), 1'b0);
    w = $random(seed);
    write_reg("enable", pid_en, w, 1'b0);
    read_reg("enable", pid_en, w & 32'h3, 1'b0); // two bits only
    write_reg("asg unmapped", asg_bad, $random(seed), 1'b1);
    read_reg("asg unmapped", asg_bad, 32'h0, 1'b1);
    write_reg("pid unmapped", pid_bad, $random(seed), 1'b1);
    read_reg("pid unmapped", pid_bad, 32'h0, 1'b1);
    end_test();

    begin_test("generator_path"); // controllers off
    set_pid(0, 0, 0, 0, 0);
    for (int k = 0; k < 3; k++) begin
      la = (k == 0) ? low14($random(seed)) : ((k == 1) ? smax : smin);
      lb = (k == 0) ? low14($random(seed)) : ((k == 1) ? smin : smax);
      set_levels(la, lb);
      wait_cycles(6);
      check_val($sformatf("dac a level %0d", la), offset_code(la), 32'(dac_a_o));
      check_val($sformatf("dac b level %0d", lb), offset_code(lb), 32'(dac_b_o));
    end
    end_test();

    begin_test("controller"); // generator at zero
    set_levels(0, 0);
    for (int en = 0; en < 4; en++) begin
      run_ctrl_case(1000, 4096, 5000, -2000, 6000, 9000, en);
    end
    for (int k = 0; k < 2; k++) begin
      run_ctrl_case(low14($random(seed)), low14($random(seed)), $random(seed) & 16383,
                    low14($random(seed)), low14($random(seed)), $random(seed) & 16383, 3);
    end
    end_test();

    begin_test("saturation");
    drive_adc(8191, 8191); // samples at zero
    set_levels(8000, -8000);
    set_pid(8191, 4096, -8192, 4096, 3);
    wait_cycles(6);
    check_val("dac a positive overflow", 32'h3FFF, 32'(dac_a_o));
    check_val("dac b negative overflow", 32'h0000, 32'(dac_b_o));
    end_test();

    if (DUT.u_asserts.fail_cnt != 0) begin
      $display("concurrent bus or reset assertions failed %0d times", DUT.u_asserts.fail_cnt);
    end
    $display("tests: %0d passed, %0d failed, %0d assertion failures",
             n_pass, n_fail, DUT.u_asserts.fail_cnt);
    if (n_fail == 0 && DUT.u_asserts.fail_cnt == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

//--- verilog.f
common/rp_pkg.sv
hdl/rp_sys_decoder.sv
analog/rp_adc_frontend.sv
asg/rp_asg_dc.sv
pid/rp_pid_regs.sv
pid/rp_pid_core.sv
hdl/rp_dac_mixer.sv
hdl/rp_top.sv
verif/rp_top_asserts.sv
verif/tb_rp_top.sv

//--- run.sh
#!/usr/bin/env bash
# compile and run the testbench with Verilator, then scan the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

if ! verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_rp_top -f verilog.f -Mdir "$OBJ" -o sim_tb_rp_top; then
  echo "build failed"
  exit 1
fi

"./$OBJ/sim_tb_rp_top" +verilator+error+limit+1000 > "$LOG" 2>&1
status=$?
cat "$LOG"

if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "Result: FAILED" "$LOG"; then
  exit 1
fi

if ! grep -q "Result: PASSED" "$LOG"; then
  echo "no result line in $LOG"
  exit 1
fi

exit 0
